// ==== logic/control_defines.svh ====
`ifndef CONTROL_DEFINES_SVH
`define CONTROL_DEFINES_SVH

// data path and instruction word width.
`define CTRL_XLEN 32

// register file addressing.
`define CTRL_REG_W 5

// hard-wired zero register, also the "no register" marker.
`define CTRL_REG_ZERO 5'd0

// link register written by jal.
`define CTRL_REG_RA 5'd31

`endif

// ==== logic/isa_pkg.sv ====
`default_nettype none

`include "control_defines.svh"

package isa_pkg;

	//////////////////////////////
	// instruction word views
	//////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		logic [`CTRL_REG_W-1:0] rs;
		logic [`CTRL_REG_W-1:0] rt;
		logic [`CTRL_REG_W-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0] op;
		logic [`CTRL_REG_W-1:0] rs;
		logic [`CTRL_REG_W-1:0] rt;
		logic [`CTRL_XLEN/2-1:0] imm16; // lower half of the word.
	} i_fields_t;

	// same 32 bits, read as R-format or I-format.
	typedef union packed {
		r_fields_t r_fields;
		i_fields_t i_fields;
	} instr_word_t;

	//////////////////////////////
	// decoded instruction
	//////////////////////////////

	typedef enum logic [5:0] {
		UNKNOWN,
		ADDU, SUBU, ADD, SUB, SLL, SRL, SRA, AND,
		OR, NOR, XOR, SLT, SLTU, SLLV, SRLV, SRAV,
		LUI, ORI, ADDI, ADDIU, ANDI, XORI, SLTI, SLTIU,
		LW, LH, LHU, LB, LBU, SW, SH, SB,
		BEQ, BNE, BLEZ, BGEZ, BLTZ, BGTZ,
		J, JAL, JR, JALR,
		MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO
	} instr_kind_t;

	// datapath usage of an instruction, drives most control decisions.
	typedef enum logic [3:0] {
		CAL_R, CAL_I, LOAD, STORE, BRANCH, JUMP_I, JUMP_R,
		CAL_M, LOAD_M, STORE_M, NONE
	} instr_class_t;

endpackage

`default_nettype wire

// ==== logic/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

	// next pc selection, resolved in D.
	typedef enum logic [3:0] {
		NPC_DISABLED,
		NPC_EQUAL,
		NPC_NOT_EQUAL,
		NPC_LE_ZERO,
		NPC_GE_ZERO,
		NPC_LT_ZERO,
		NPC_GT_ZERO,
		NPC_J,
		NPC_REG
	} npc_mode_t;

	typedef enum logic [1:0] {
		EXT_SIGNED, EXT_UNSIGNED, EXT_PAD // pad moves imm16 to the upper half.
	} ext_mode_t;

	typedef enum logic [4:0] {
		ALU_ADDU, ALU_SUBU, ALU_ADD, ALU_SUB,
		ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL,
		ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV
	} alu_op_t;

	typedef enum logic [3:0] {
		MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU,
		MD_MFHI, MD_MFLO, MD_MTHI, MD_MTLO
	} md_op_t;

	typedef enum logic [2:0] {
		DM_NONE, DM_W, DM_H, DM_HU, DM_B, DM_BU
	} dm_mode_t;

	// write-back data source.
	typedef enum logic [2:0] {
		WB_NONE, WB_ALU, WB_MEM, WB_LINK, WB_MD
	} wb_sel_t;

endpackage

`default_nettype wire

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  isa_pkg::instr_word_t  instr,
	output isa_pkg::instr_kind_t  kind,
	output isa_pkg::instr_class_t iclass
);

	logic rs_z, rt_z, rd_z, sh_z;

	// reserved fields must be zero for a legal encoding.
	assign rs_z = (instr.r_fields.rs == '0);
	assign rt_z = (instr.r_fields.rt == '0);
	assign rd_z = (instr.r_fields.rd == '0);
	assign sh_z = (instr.r_fields.shamt == '0);

	always_comb begin
		kind = isa_pkg::UNKNOWN; // anything unmatched is reserved.
		case (instr.r_fields.op)
			6'b000000: begin
				case (instr.r_fields.funct)
					6'b100001: if (sh_z) kind = isa_pkg::ADDU;
					6'b100011: if (sh_z) kind = isa_pkg::SUBU;
					6'b100000: if (sh_z) kind = isa_pkg::ADD;
					6'b100010: if (sh_z) kind = isa_pkg::SUB;
					6'b000000: if (rs_z) kind = isa_pkg::SLL; // shifts by shamt.
					6'b000010: if (rs_z) kind = isa_pkg::SRL;
					6'b000011: if (rs_z) kind = isa_pkg::SRA;
					6'b100100: if (sh_z) kind = isa_pkg::AND;
					6'b100101: if (sh_z) kind = isa_pkg::OR;
					6'b100111: if (sh_z) kind = isa_pkg::NOR;
					6'b100110: if (sh_z) kind = isa_pkg::XOR;
					6'b101010: if (sh_z) kind = isa_pkg::SLT;
					6'b101011: if (sh_z) kind = isa_pkg::SLTU;
					6'b000100: if (sh_z) kind = isa_pkg::SLLV;
					6'b000110: if (sh_z) kind = isa_pkg::SRLV;
					6'b000111: if (sh_z) kind = isa_pkg::SRAV;
					6'b001000: if (rt_z && rd_z) kind = isa_pkg::JR;
					6'b001001: if (rt_z) kind = isa_pkg::JALR;
					6'b011000: if (rd_z && sh_z) kind = isa_pkg::MULT;
					6'b011001: if (rd_z && sh_z) kind = isa_pkg::MULTU;
					6'b011010: if (rd_z && sh_z) kind = isa_pkg::DIV;
					6'b011011: if (rd_z && sh_z) kind = isa_pkg::DIVU;
					6'b010000: if (rs_z && rt_z && sh_z) kind = isa_pkg::MFHI;
					6'b010010: if (rs_z && rt_z && sh_z) kind = isa_pkg::MFLO;
					6'b010001: if (rt_z && rd_z && sh_z) kind = isa_pkg::MTHI;
					6'b010011: if (rt_z && rd_z && sh_z) kind = isa_pkg::MTLO;
					default: ;
				endcase
			end
			6'b000001: begin // regimm, condition sits in rt.
				if (instr.i_fields.rt == 5'b00001)
					kind = isa_pkg::BGEZ;
				else if (rt_z)
					kind = isa_pkg::BLTZ;
			end
			6'b001111: if (rs_z) kind = isa_pkg::LUI;
			6'b001101: kind = isa_pkg::ORI;
			6'b001000: kind = isa_pkg::ADDI;
			6'b001001: kind = isa_pkg::ADDIU;
			6'b001100: kind = isa_pkg::ANDI;
			6'b001110: kind = isa_pkg::XORI;
			6'b001010: kind = isa_pkg::SLTI;
			6'b001011: kind = isa_pkg::SLTIU;
			6'b100011: kind = isa_pkg::LW;
			6'b100001: kind = isa_pkg::LH;
			6'b100101: kind = isa_pkg::LHU;
			6'b100000: kind = isa_pkg::LB;
			6'b100100: kind = isa_pkg::LBU;
			6'b101011: kind = isa_pkg::SW;
			6'b101001: kind = isa_pkg::SH;
			6'b101000: kind = isa_pkg::SB;
			6'b000100: kind = isa_pkg::BEQ;
			6'b000101: kind = isa_pkg::BNE;
			6'b000110: kind = isa_pkg::BLEZ;
			6'b000111: if (rt_z) kind = isa_pkg::BGTZ;
			6'b000010: kind = isa_pkg::J;
			6'b000011: kind = isa_pkg::JAL;
			default: ;
		endcase
	end

	always_comb begin
		case (kind)
			isa_pkg::ADDU, isa_pkg::SUBU, isa_pkg::ADD, isa_pkg::SUB,
			isa_pkg::SLL, isa_pkg::SRL, isa_pkg::SRA, isa_pkg::AND,
			isa_pkg::OR, isa_pkg::NOR, isa_pkg::XOR, isa_pkg::SLT,
			isa_pkg::SLTU, isa_pkg::SLLV, isa_pkg::SRLV, isa_pkg::SRAV:
				iclass = isa_pkg::CAL_R;
			isa_pkg::LUI, isa_pkg::ORI, isa_pkg::ADDI, isa_pkg::ADDIU,
			isa_pkg::ANDI, isa_pkg::XORI, isa_pkg::SLTI, isa_pkg::SLTIU:
				iclass = isa_pkg::CAL_I;
			isa_pkg::LW, isa_pkg::LH, isa_pkg::LHU, isa_pkg::LB, isa_pkg::LBU:
				iclass = isa_pkg::LOAD;
			isa_pkg::SW, isa_pkg::SH, isa_pkg::SB:
				iclass = isa_pkg::STORE;
			isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLEZ,
			isa_pkg::BGEZ, isa_pkg::BLTZ, isa_pkg::BGTZ:
				iclass = isa_pkg::BRANCH;
			isa_pkg::J, isa_pkg::JAL:
				iclass = isa_pkg::JUMP_I;
			isa_pkg::JR, isa_pkg::JALR:
				iclass = isa_pkg::JUMP_R;
			isa_pkg::MULT, isa_pkg::MULTU, isa_pkg::DIV, isa_pkg::DIVU:
				iclass = isa_pkg::CAL_M;
			isa_pkg::MFHI, isa_pkg::MFLO:
				iclass = isa_pkg::LOAD_M;
			isa_pkg::MTHI, isa_pkg::MTLO:
				iclass = isa_pkg::STORE_M;
			default:
				iclass = isa_pkg::NONE; // unknown lands here.
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/reg_track.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_defines.svh"

module reg_track (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    stall,
	input  isa_pkg::instr_word_t    d_instr,
	input  isa_pkg::instr_kind_t    d_kind,
	input  isa_pkg::instr_class_t   d_class,
	output logic [`CTRL_REG_W-1:0]  d_reg1,
	output logic [`CTRL_REG_W-1:0]  d_reg2,
	output logic [`CTRL_REG_W-1:0]  e_regw,
	output logic [`CTRL_REG_W-1:0]  rf_write_addr
);

	logic [`CTRL_REG_W-1:0] d_regw;

	// triple layout: [2] write reg, [1] reg2, [0] reg1.
	logic [2:0][`CTRL_REG_W-1:0] e_regs, m_regs, w_regs;

	//////////////////////////////
	// register identification
	//////////////////////////////

	always_comb begin
		d_reg1 = `CTRL_REG_ZERO;
		d_reg2 = `CTRL_REG_ZERO;
		d_regw = `CTRL_REG_ZERO;
		if (d_class inside {isa_pkg::CAL_R, isa_pkg::CAL_I, isa_pkg::LOAD, isa_pkg::STORE,
				isa_pkg::BRANCH, isa_pkg::JUMP_R, isa_pkg::CAL_M, isa_pkg::STORE_M})
			d_reg1 = d_instr.r_fields.rs;
		// only beq and bne compare two registers.
		if (d_class inside {isa_pkg::CAL_R, isa_pkg::STORE, isa_pkg::CAL_M} ||
				d_kind inside {isa_pkg::BEQ, isa_pkg::BNE})
			d_reg2 = d_instr.r_fields.rt;
		if (d_class inside {isa_pkg::CAL_R, isa_pkg::LOAD_M} || d_kind == isa_pkg::JALR)
			d_regw = d_instr.r_fields.rd;
		else if (d_class inside {isa_pkg::CAL_I, isa_pkg::LOAD})
			d_regw = d_instr.i_fields.rt;
		else if (d_kind == isa_pkg::JAL)
			d_regw = `CTRL_REG_RA; // implicit link target.
	end

	//////////////////////////////
	// E, M, W register pipeline
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_regs <= '0;
			m_regs <= '0;
			w_regs <= '0;
		end else begin
			e_regs <= stall ? '0 : {d_regw, d_reg2, d_reg1}; // bubble on stall.
			m_regs <= e_regs;
			w_regs <= m_regs;
		end
	end

	assign e_regw = e_regs[2];
	assign rf_write_addr = w_regs[2];

endmodule

`default_nettype wire

// ==== logic/stage_signals.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_signals (
	input  isa_pkg::instr_kind_t  d_kind,
	input  isa_pkg::instr_kind_t  e_kind,
	input  isa_pkg::instr_kind_t  m_kind,
	input  isa_pkg::instr_kind_t  w_kind,
	input  isa_pkg::instr_class_t d_class,
	input  isa_pkg::instr_class_t e_class,
	input  isa_pkg::instr_class_t m_class,
	input  isa_pkg::instr_class_t w_class,
	output ctrl_pkg::npc_mode_t   npc_mode,
	output ctrl_pkg::ext_mode_t   ext_mode,
	output logic                  alu_src,
	output ctrl_pkg::alu_op_t     alu_op,
	output ctrl_pkg::md_op_t      md_op,
	output logic                  dm_write_enable,
	output ctrl_pkg::dm_mode_t    dm_mode,
	output logic                  rf_write_enable,
	output ctrl_pkg::wb_sel_t     wb_sel
);

	//////////////////////////////
	// D stage
	//////////////////////////////

	always_comb begin
		npc_mode = ctrl_pkg::NPC_DISABLED;
		case (d_class)
			isa_pkg::BRANCH: begin
				case (d_kind)
					isa_pkg::BEQ:  npc_mode = ctrl_pkg::NPC_EQUAL;
					isa_pkg::BNE:  npc_mode = ctrl_pkg::NPC_NOT_EQUAL;
					isa_pkg::BLEZ: npc_mode = ctrl_pkg::NPC_LE_ZERO;
					isa_pkg::BGEZ: npc_mode = ctrl_pkg::NPC_GE_ZERO;
					isa_pkg::BLTZ: npc_mode = ctrl_pkg::NPC_LT_ZERO;
					isa_pkg::BGTZ: npc_mode = ctrl_pkg::NPC_GT_ZERO;
					default: ;
				endcase
			end
			isa_pkg::JUMP_I: npc_mode = ctrl_pkg::NPC_J;
			isa_pkg::JUMP_R: npc_mode = ctrl_pkg::NPC_REG; // target from rs.
			default: ;
		endcase
	end

	// logical immediates are zero extended.
	always_comb begin
		if (d_kind == isa_pkg::LUI)
			ext_mode = ctrl_pkg::EXT_PAD;
		else if (d_kind inside {isa_pkg::ORI, isa_pkg::ANDI, isa_pkg::XORI})
			ext_mode = ctrl_pkg::EXT_UNSIGNED;
		else
			ext_mode = ctrl_pkg::EXT_SIGNED;
	end

	//////////////////////////////
	// E stage
	//////////////////////////////

	assign alu_src = (e_class inside {isa_pkg::CAL_I, isa_pkg::LOAD, isa_pkg::STORE});

	always_comb begin
		alu_op = ctrl_pkg::ALU_OR; // lui and non-alu classes pass through or.
		case (e_kind)
			isa_pkg::ADDU, isa_pkg::ADDIU: alu_op = ctrl_pkg::ALU_ADDU;
			isa_pkg::ADD, isa_pkg::ADDI:   alu_op = ctrl_pkg::ALU_ADD;
			isa_pkg::SUBU:                 alu_op = ctrl_pkg::ALU_SUBU;
			isa_pkg::SUB:                  alu_op = ctrl_pkg::ALU_SUB;
			isa_pkg::AND, isa_pkg::ANDI:   alu_op = ctrl_pkg::ALU_AND;
			isa_pkg::NOR:                  alu_op = ctrl_pkg::ALU_NOR;
			isa_pkg::XOR, isa_pkg::XORI:   alu_op = ctrl_pkg::ALU_XOR;
			isa_pkg::SLT, isa_pkg::SLTI:   alu_op = ctrl_pkg::ALU_SLT;
			isa_pkg::SLTU, isa_pkg::SLTIU: alu_op = ctrl_pkg::ALU_SLTU;
			isa_pkg::SLL:                  alu_op = ctrl_pkg::ALU_SLL;
			isa_pkg::SRL:                  alu_op = ctrl_pkg::ALU_SRL;
			isa_pkg::SRA:                  alu_op = ctrl_pkg::ALU_SRA;
			isa_pkg::SLLV:                 alu_op = ctrl_pkg::ALU_SLLV;
			isa_pkg::SRLV:                 alu_op = ctrl_pkg::ALU_SRLV;
			isa_pkg::SRAV:                 alu_op = ctrl_pkg::ALU_SRAV;
			default: ;
		endcase
		if (e_class inside {isa_pkg::LOAD, isa_pkg::STORE})
			alu_op = ctrl_pkg::ALU_ADD; // address = base + offset.
	end

	always_comb begin
		case (e_kind)
			isa_pkg::MULT:  md_op = ctrl_pkg::MD_MULT;
			isa_pkg::MULTU: md_op = ctrl_pkg::MD_MULTU;
			isa_pkg::DIV:   md_op = ctrl_pkg::MD_DIV;
			isa_pkg::DIVU:  md_op = ctrl_pkg::MD_DIVU;
			isa_pkg::MFHI:  md_op = ctrl_pkg::MD_MFHI;
			isa_pkg::MFLO:  md_op = ctrl_pkg::MD_MFLO;
			isa_pkg::MTHI:  md_op = ctrl_pkg::MD_MTHI;
			isa_pkg::MTLO:  md_op = ctrl_pkg::MD_MTLO;
			default:        md_op = ctrl_pkg::MD_NONE;
		endcase
	end

	//////////////////////////////
	// M and W stages
	//////////////////////////////

	assign dm_write_enable = (m_class == isa_pkg::STORE);

	always_comb begin
		case (m_kind)
			isa_pkg::LW, isa_pkg::SW: dm_mode = ctrl_pkg::DM_W;
			isa_pkg::LH, isa_pkg::SH: dm_mode = ctrl_pkg::DM_H;
			isa_pkg::LHU:             dm_mode = ctrl_pkg::DM_HU;
			isa_pkg::LB, isa_pkg::SB: dm_mode = ctrl_pkg::DM_B;
			isa_pkg::LBU:             dm_mode = ctrl_pkg::DM_BU;
			default:                  dm_mode = ctrl_pkg::DM_NONE;
		endcase
	end

	assign rf_write_enable = (w_class inside {isa_pkg::CAL_R, isa_pkg::CAL_I, isa_pkg::LOAD,
		isa_pkg::JUMP_I, isa_pkg::JUMP_R, isa_pkg::LOAD_M});

	always_comb begin
		wb_sel = ctrl_pkg::WB_NONE;
		case (w_class)
			isa_pkg::CAL_R, isa_pkg::CAL_I:   wb_sel = ctrl_pkg::WB_ALU;
			isa_pkg::LOAD:                    wb_sel = ctrl_pkg::WB_MEM;
			isa_pkg::JUMP_I, isa_pkg::JUMP_R: wb_sel = ctrl_pkg::WB_LINK;
			isa_pkg::LOAD_M: begin
				if (w_kind inside {isa_pkg::MFHI, isa_pkg::MFLO})
					wb_sel = ctrl_pkg::WB_MD; // hi/lo readback.
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/hazard_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_defines.svh"

module hazard_detect (
	input  isa_pkg::instr_kind_t   d_kind,
	input  isa_pkg::instr_class_t  d_class,
	input  isa_pkg::instr_class_t  e_class,
	input  logic [`CTRL_REG_W-1:0] d_reg1,
	input  logic [`CTRL_REG_W-1:0] d_reg2,
	input  logic [`CTRL_REG_W-1:0] e_regw,
	input  logic                   md_busy,
	output logic                   stall
);

	logic e_match;  // E writes a register that D reads.
	logic need_now; // D consumes its sources in D, no forwarding.
	logic md_use;

	assign e_match = (e_regw != `CTRL_REG_ZERO) && (e_regw == d_reg1 || e_regw == d_reg2);
	assign need_now = (e_class == isa_pkg::LOAD) ||
		(d_class inside {isa_pkg::BRANCH, isa_pkg::JUMP_R});
	assign md_use = d_kind inside {isa_pkg::MULT, isa_pkg::MULTU, isa_pkg::DIV,
		isa_pkg::DIVU, isa_pkg::MFHI, isa_pkg::MFLO, isa_pkg::MTHI, isa_pkg::MTLO};

	assign stall = (e_match && need_now) || (md_use && md_busy);

endmodule

`default_nettype wire

// ==== logic/pipe_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_defines.svh"

module pipe_control (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   md_busy,
	input  isa_pkg::instr_word_t   d_instr,
	input  isa_pkg::instr_word_t   e_instr,
	input  isa_pkg::instr_word_t   m_instr,
	input  isa_pkg::instr_word_t   w_instr,
	output ctrl_pkg::npc_mode_t    npc_mode,
	output ctrl_pkg::ext_mode_t    ext_mode,
	output logic                   alu_src,
	output ctrl_pkg::alu_op_t      alu_op,
	output ctrl_pkg::md_op_t       md_op,
	output logic                   dm_write_enable,
	output ctrl_pkg::dm_mode_t     dm_mode,
	output logic                   rf_write_enable,
	output ctrl_pkg::wb_sel_t      wb_sel,
	output logic [`CTRL_REG_W-1:0] rf_read_addr1,
	output logic [`CTRL_REG_W-1:0] rf_read_addr2,
	output logic [`CTRL_REG_W-1:0] rf_write_addr,
	output logic                   pc_enable,
	output logic                   d_enable,
	output logic                   e_flush
);

	isa_pkg::instr_kind_t   d_kind, e_kind, m_kind, w_kind;
	isa_pkg::instr_class_t  d_class, e_class, m_class, w_class;
	logic [`CTRL_REG_W-1:0] d_reg1, d_reg2, e_regw;
	logic                   stall;

	// one decoder per stage.
	instr_decode d_decode (.instr(d_instr), .kind(d_kind), .iclass(d_class));
	instr_decode e_decode (.instr(e_instr), .kind(e_kind), .iclass(e_class));
	instr_decode m_decode (.instr(m_instr), .kind(m_kind), .iclass(m_class));
	instr_decode w_decode (.instr(w_instr), .kind(w_kind), .iclass(w_class));

	reg_track reg_track_i (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.d_instr(d_instr),
		.d_kind(d_kind),
		.d_class(d_class),
		.d_reg1(d_reg1),
		.d_reg2(d_reg2),
		.e_regw(e_regw),
		.rf_write_addr(rf_write_addr)
	);

	stage_signals stage_signals_i (
		.d_kind(d_kind),
		.e_kind(e_kind),
		.m_kind(m_kind),
		.w_kind(w_kind),
		.d_class(d_class),
		.e_class(e_class),
		.m_class(m_class),
		.w_class(w_class),
		.npc_mode(npc_mode),
		.ext_mode(ext_mode),
		.alu_src(alu_src),
		.alu_op(alu_op),
		.md_op(md_op),
		.dm_write_enable(dm_write_enable),
		.dm_mode(dm_mode),
		.rf_write_enable(rf_write_enable),
		.wb_sel(wb_sel)
	);

	hazard_detect hazard_detect_i (
		.d_kind(d_kind),
		.d_class(d_class),
		.e_class(e_class),
		.d_reg1(d_reg1),
		.d_reg2(d_reg2),
		.e_regw(e_regw),
		.md_busy(md_busy),
		.stall(stall)
	);

	assign rf_read_addr1 = d_reg1; // D sources double as rf read ports.
	assign rf_read_addr2 = d_reg2;

	// stall freezes F and D, and E takes a bubble.
	assign pc_enable = ~stall;
	assign d_enable = ~stall;
	assign e_flush = stall;

endmodule

`default_nettype wire

// ==== bench/pipe_control_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_defines.svh"

module pipe_control_properties (
	input logic                   clk,
	input logic                   arst_n,
	input logic                   stall,
	input logic                   pc_enable,
	input logic                   e_flush,
	input logic                   rf_write_enable,
	input logic [`CTRL_REG_W-1:0] e_regw,
	input logic [`CTRL_REG_W-1:0] rf_write_addr
);

	// F enable and E flush are two views of one stall.
	enable_vs_flush: assert property (@(posedge clk) disable iff (!arst_n)
		pc_enable == !e_flush)
		else $error("pc_enable and e_flush disagree");

	bubble_after_stall: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> e_regw == `CTRL_REG_ZERO)
		else $error("E write register not cleared after a stall");

	// no write means no write target.
	idle_write_addr: assert property (@(posedge clk) disable iff (!arst_n)
		!rf_write_enable |-> rf_write_addr == `CTRL_REG_ZERO)
		else $error("rf_write_addr is %0d with rf_write_enable low", rf_write_addr);

endmodule

bind pipe_control pipe_control_properties props_i (
	.clk(clk),
	.arst_n(arst_n),
	.stall(stall),
	.pc_enable(pc_enable),
	.e_flush(e_flush),
	.rf_write_enable(rf_write_enable),
	.e_regw(e_regw),
	.rf_write_addr(rf_write_addr)
);

`default_nettype wire

// ==== bench/pipe_control_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "control_defines.svh"

module pipe_control_tb;

	localparam int FIELDS = 10;          // expected columns per trace line.
	localparam int MAX_LINES = 400;
	localparam int RESET_CYCLES = 4;
	localparam int ENABLE_TIMEOUT = 16;

	logic                   clk;
	logic                   arst_n;
	logic                   md_busy;
	isa_pkg::instr_word_t   d_instr, e_instr, m_instr, w_instr;
	ctrl_pkg::npc_mode_t    npc_mode;
	ctrl_pkg::ext_mode_t    ext_mode;
	logic                   alu_src;
	ctrl_pkg::alu_op_t      alu_op;
	ctrl_pkg::md_op_t       md_op;
	logic                   dm_write_enable;
	ctrl_pkg::dm_mode_t     dm_mode;
	logic                   rf_write_enable;
	ctrl_pkg::wb_sel_t      wb_sel;
	logic [`CTRL_REG_W-1:0] rf_read_addr1, rf_read_addr2, rf_write_addr;
	logic                   pc_enable, d_enable, e_flush;

	// reference pipeline, one word per stage.
	logic [`CTRL_XLEN-1:0] d_word, e_word, m_word, w_word;
	logic held; // D was frozen in the previous cycle.

	int expected [FIELDS];
	int actual [FIELDS];
	string field_name [FIELDS] = '{"stall", "npc_mode", "ext_mode", "alu_src", "alu_op",
		"md_op", "dm_mode", "wb_sel", "rf_write_enable", "rf_write_addr"};
	int tests, failed_tests, errors;
	bit aborted;

	pipe_control dut_i (.*);

	always #2 clk = ~clk;

	//////////////////////////////
	// pipeline model
	//////////////////////////////

	task automatic advance_pipeline(input logic [`CTRL_XLEN-1:0] fetched, input logic busy);
		w_word = m_word;
		m_word = e_word;
		if (held) begin
			e_word = '0; // bubble, D keeps its word.
		end else begin
			e_word = d_word;
			d_word = fetched;
		end
		d_instr = d_word;
		e_instr = e_word;
		m_instr = m_word;
		w_instr = w_word;
		md_busy = busy;
	endtask

	// legal special-opcode encodings keep their unused fields at zero.
	function automatic bit special_legal(input logic [`CTRL_XLEN-1:0] w);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sh;
		rs = w[25:21];
		rt = w[20:16];
		rd = w[15:11];
		sh = w[10:6];
		case (w[5:0])
			6'h00, 6'h02, 6'h03: return rs == 5'd0;
			6'h04, 6'h06, 6'h07, 6'h20, 6'h21, 6'h22, 6'h23,
			6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: return sh == 5'd0;
			6'h08: return rt == 5'd0 && rd == 5'd0;
			6'h09: return rt == 5'd0;
			6'h18, 6'h19, 6'h1a, 6'h1b: return rd == 5'd0 && sh == 5'd0;
			6'h10, 6'h12: return rs == 5'd0 && rt == 5'd0 && sh == 5'd0;
			6'h11, 6'h13: return rt == 5'd0 && rd == 5'd0 && sh == 5'd0;
			default: return 1'b0;
		endcase
	endfunction

	// source registers that the word in D reads from the register file.
	task automatic expected_reads(input logic [`CTRL_XLEN-1:0] w, output int r1,
		output int r2);
		r1 = 0;
		r2 = 0;
		case (w[31:26])
			6'h00: begin
				if (special_legal(w)) begin
					r1 = w[25:21];
					r2 = w[20:16];
				end
			end
			6'h01: if (w[20:16] <= 5'd1) r1 = w[25:21]; // bltz, bgez.
			6'h04, 6'h05, 6'h28, 6'h29, 6'h2b: begin
				r1 = w[25:21];
				r2 = w[20:16];
			end
			6'h07: if (w[20:16] == 5'd0) r1 = w[25:21];
			6'h06, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e,
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25: r1 = w[25:21];
			default: ; // lui, j, jal and reserved words read nothing.
		endcase
	endtask

	function automatic int is_store_word(input logic [`CTRL_XLEN-1:0] w);
		return (w[31:26] inside {6'h28, 6'h29, 6'h2b}) ? 1 : 0;
	endfunction

	task automatic sample_outputs();
		actual[0] = int'(e_flush);
		actual[1] = int'(npc_mode);
		actual[2] = int'(ext_mode);
		actual[3] = int'(alu_src);
		actual[4] = int'(alu_op);
		actual[5] = int'(md_op);
		actual[6] = int'(dm_mode);
		actual[7] = int'(wb_sel);
		actual[8] = int'(rf_write_enable);
		actual[9] = int'(rf_write_addr);
	endtask

	task automatic compare_field(input string name, input string field, input int exp_val,
		input int act_val, inout bit ok);
		if (act_val != exp_val) begin
			$display("MISMATCH %s %s: expected %0d, actual %0d", name, field, exp_val,
				act_val);
			errors++;
			ok = 1'b0;
		end
	endtask

	task automatic wait_enabled(input int limit);
		int n;
		n = 0;
		while (pc_enable !== 1'b1 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (pc_enable !== 1'b1) begin
			$display("timeout: pc_enable did not rise within %0d cycles of reset", limit);
			aborted = 1'b1;
		end
	endtask

	//////////////////////////////
	// one trace line per cycle
	//////////////////////////////

	task automatic run_line(input string line);
		string name;
		logic [`CTRL_XLEN-1:0] word;
		int busy;
		int sp;
		int got;
		int i;
		int exp_r1;
		int exp_r2;
		int exp_run;
		bit ok;
		sp = 0;
		while (sp < line.len() && line[sp] != " ")
			sp++;
		name = line.substr(0, sp - 1);
		got = $sscanf(line.substr(sp, line.len() - 1),
			"%h %d %d %d %d %d %d %d %d %d %d %d", word, busy,
			expected[0], expected[1], expected[2], expected[3], expected[4],
			expected[5], expected[6], expected[7], expected[8], expected[9]);
		tests++;
		if (got != FIELDS + 2) begin
			$display("trace line %s holds %0d readable fields instead of %0d", name, got,
				FIELDS + 2);
			errors++;
			failed_tests++;
		end else begin
			@(negedge clk);
			advance_pipeline(word, busy != 0);
			#1; // combinational outputs settle well before the rising edge.
			sample_outputs();
			ok = 1'b1;
			for (i = 0; i < FIELDS; i++)
				compare_field(name, field_name[i], expected[i], actual[i], ok);
			exp_run = (expected[0] != 0) ? 0 : 1;
			compare_field(name, "pc_enable", exp_run, int'(pc_enable), ok);
			compare_field(name, "d_enable", exp_run, int'(d_enable), ok);
			compare_field(name, "dm_write_enable", is_store_word(m_word),
				int'(dm_write_enable), ok);
			expected_reads(d_word, exp_r1, exp_r2);
			compare_field(name, "rf_read_addr1", exp_r1, int'(rf_read_addr1), ok);
			compare_field(name, "rf_read_addr2", exp_r2, int'(rf_read_addr2), ok);
			held = (expected[0] != 0);
			if (!ok)
				failed_tests++;
			$display("test %s: %s", name, ok ? "ok" : "FAILED");
		end
	endtask

	initial begin
		string line;
		int fd;
		int lines;
		clk = 1'b0;
		arst_n = 1'b0;
		md_busy = 1'b0;
		d_instr = '0;
		e_instr = '0;
		m_instr = '0;
		w_instr = '0;
		d_word = '0;
		e_word = '0;
		m_word = '0;
		w_word = '0;
		held = 1'b0;
		tests = 0;
		failed_tests = 0;
		errors = 0;
		aborted = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		wait_enabled(ENABLE_TIMEOUT);
		if (!aborted) begin
			fd = $fopen("bench/control_trace.txt", "r");
			if (fd == 0) begin
				$display("cannot open the trace file bench/control_trace.txt");
				aborted = 1'b1;
			end else begin
				lines = 0;
				while (!$feof(fd) && lines < MAX_LINES) begin
					lines++;
					line = "";
					if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#")
						run_line(line);
				end
				if (!$feof(fd)) begin
					$display("trace file has more than %0d lines", MAX_LINES);
					aborted = 1'b1;
				end
				$fclose(fd);
			end
		end
		$display("tests run %0d, failed %0d, mismatches %0d", tests, failed_tests, errors);
		if (errors == 0 && !aborted && tests > 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/control_trace.txt ====
# name word md_busy stall npc_mode ext_mode alu_src alu_op md_op dm_mode wb_sel rf_we rf_waddr
# codes are ctrl_pkg enum positions; the word is ignored in a cycle where D holds.
addu 00221821 0 0 0 0 0 10 0 0 1 1 0
subu 00222023 0 0 0 0 0 0 0 0 1 1 0
add 00222820 0 0 0 0 0 1 0 0 1 1 0
sub 00223022 0 0 0 0 0 2 0 0 1 1 3
sll 00023900 0 0 0 0 0 3 0 0 1 1 4
srl 00024102 0 0 0 0 0 10 0 0 1 1 5
sra 00024903 0 0 0 0 0 11 0 0 1 1 6
and 00225024 0 0 0 0 0 12 0 0 1 1 7
or 00225825 0 0 0 0 0 4 0 0 1 1 8
nor 00226027 0 0 0 0 0 5 0 0 1 1 9
xor 00226826 0 0 0 0 0 6 0 0 1 1 10
slt 0022702a 0 0 0 0 0 7 0 0 1 1 11
sltu 0022782b 0 0 0 0 0 8 0 0 1 1 12
sllv 00228004 0 0 0 0 0 9 0 0 1 1 13
srlv 00228806 0 0 0 0 0 13 0 0 1 1 14
srav 00229007 0 0 0 0 0 14 0 0 1 1 15
lui 3c131234 0 0 0 2 0 15 0 0 1 1 16
ori 343400ff 0 0 0 1 1 5 0 0 1 1 17
addi 2035fffc 0 0 0 0 1 5 0 0 1 1 18
addiu 24360008 0 0 0 0 1 2 0 0 1 1 19
andi 30370f0f 0 0 0 1 1 0 0 0 1 1 20
xori 38385555 0 0 0 1 1 4 0 0 1 1 21
slti 2839ffff 0 0 0 0 1 7 0 0 1 1 22
sltiu 2c3a0010 0 0 0 0 1 8 0 0 1 1 23
lw 8c3b0000 0 0 0 0 1 9 0 0 1 1 24
lh 843c0002 0 0 0 0 1 2 0 0 1 1 25
lhu 943d0004 0 0 0 0 1 2 0 1 1 1 26
lb 803e0001 0 0 0 0 1 2 0 2 2 1 27
lbu 90250003 0 0 0 0 1 2 0 3 2 1 28
sw ac220008 0 0 0 0 1 2 0 4 2 1 29
sh a4220006 0 0 0 0 1 2 0 5 2 1 30
sb a0220005 0 0 0 0 1 2 0 1 2 1 5
load_r6 8c260000 0 0 0 0 1 2 0 2 0 0 0
use_stall 00c23821 0 1 0 0 1 2 0 4 0 0 0
use_held 00c23821 0 0 0 0 0 10 0 1 0 0 0
jal 0c000100 0 0 7 0 0 0 0 0 2 1 6
mult_busy 00220018 1 1 0 0 0 5 0 0 1 1 0
mult_wait 00220018 1 1 0 0 0 10 0 0 1 1 7
mult_go 00220018 0 0 0 0 0 10 0 0 3 1 31
mflo 00004012 0 0 0 0 0 5 1 0 1 1 0
reserved 00224860 0 0 0 0 0 5 6 0 1 1 0
addu_r10 00225021 0 0 0 0 0 5 0 0 0 0 0
beq_stall 11420008 0 1 1 0 0 0 0 0 4 1 8
beq_held 11420008 0 0 1 0 0 10 0 0 0 0 0
drain1 00000000 0 0 0 0 0 5 0 0 1 1 10
drain2 00000000 0 0 0 0 0 10 0 0 1 1 0
drain3 00000000 0 0 0 0 0 10 0 0 0 0 0

// ==== list.f ====
+incdir+logic
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/instr_decode.sv
logic/reg_track.sv
logic/stage_signals.sv
logic/hazard_detect.sv
logic/pipe_control.sv
bench/pipe_control_properties.sv
bench/pipe_control_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pipe_control_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
